// File: design/fifo_settings.svh
`ifndef FIFO_SETTINGS_SVH
`define FIFO_SETTINGS_SVH

// write side takes one full word per strobe
`define FIFO_WORD_WIDTH 32

// read side hands out one lane per strobe
`define FIFO_LANE_WIDTH 8

// lanes per word, must be a power of two
`define FIFO_LANES 4

// storage depth in words
`define FIFO_DEPTH 16

// word pointer carries one wrap bit above the 4 bit address
`define FIFO_WORD_PTR_WIDTH 5

// lane pointer is the word pointer plus 2 lane index bits
`define FIFO_LANE_PTR_WIDTH 7

// prog_full level in words, prog_empty level in lanes
`define FIFO_PROG_FULL_THRESH 12
`define FIFO_PROG_EMPTY_THRESH 8

`endif

// File: design/fifo_pkg.sv
`default_nettype none

`include "fifo_settings.svh"

package fifo_pkg;

    // one word as written
    typedef logic [`FIFO_WORD_WIDTH-1:0] word_t;

    // one lane as read back
    typedef logic [`FIFO_LANE_WIDTH-1:0] lane_t;

    // write request toward the word memory
    typedef struct packed {
        logic                            en;
        logic [`FIFO_WORD_PTR_WIDTH-2:0] addr;
        word_t                           data;
    } ram_wr_t;

    // read request toward the word memory
    // lane rides along so the unpack stage knows which slice to pick
    typedef struct packed {
        logic                                                en;
        logic [`FIFO_WORD_PTR_WIDTH-2:0]                     addr;
        logic [`FIFO_LANE_PTR_WIDTH-`FIFO_WORD_PTR_WIDTH-1:0] lane;
    } ram_rd_t;

    // occupancy, words on the write side and lanes on the read side
    typedef struct packed {
        logic [`FIFO_WORD_PTR_WIDTH-1:0] wr_count;
        logic [`FIFO_LANE_PTR_WIDTH-1:0] rd_count;
    } fifo_count_t;

    // status outputs bundled for the top level
    typedef struct packed {
        logic almost_full;
        logic almost_empty;
        logic prog_full;
        logic prog_empty;
        logic overflow;
        logic underflow;
    } fifo_flags_t;

endpackage

`default_nettype wire

// File: design/fifo_pointers.sv
`timescale 1ns/1ps
`default_nettype none

`include "fifo_settings.svh"

module fifo_pointers
    import fifo_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        wr_en,
    input  word_t       data_in,
    input  logic        rd_en,
    output ram_wr_t     ram_wr,
    output ram_rd_t     ram_rd,
    output logic        full,
    output logic        empty,
    output logic        wr_ack,
    output fifo_count_t counts
);

    // write pointer in words, msb is the wrap bit
    logic [`FIFO_WORD_PTR_WIDTH-1:0] wr_ptr;
    // read pointer in lanes, low bits are the lane index
    logic [`FIFO_LANE_PTR_WIDTH-1:0] rd_ptr;
    // read pointer seen as a word pointer
    logic [`FIFO_WORD_PTR_WIDTH-1:0] rd_word_ptr;
    // write pointer scaled up to lanes
    logic [`FIFO_LANE_PTR_WIDTH-1:0] wr_lane_ptr;
    logic                            wr_accept;
    logic                            rd_accept;

    // strobes are judged against the flags as they stand this cycle
    assign wr_accept = wr_en & ~full;
    assign rd_accept = rd_en & ~empty;

    // acknowledge goes out in the same cycle as the write
    assign wr_ack = wr_accept;

    // upper bits of the lane pointer address the word
    assign rd_word_ptr = rd_ptr[`FIFO_LANE_PTR_WIDTH-1 -: `FIFO_WORD_PTR_WIDTH];

    // four lanes per word, so append zero lane index bits
    assign wr_lane_ptr = {wr_ptr, {(`FIFO_LANE_PTR_WIDTH-`FIFO_WORD_PTR_WIDTH){1'b0}}};

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
        end else if (wr_accept) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // steps one lane at a time, wraps into the next word on its own
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            rd_ptr <= '0;
        end else if (rd_accept) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_comb begin
        // a partly read word still holds its slot
        counts.wr_count = wr_ptr - rd_word_ptr;
        // lanes left, modulo pointer arithmetic handles the wrap
        counts.rd_count = wr_lane_ptr - rd_ptr;
    end

    // full at depth words, empty once every lane has gone
    assign full  = (counts.wr_count == `FIFO_WORD_PTR_WIDTH'(`FIFO_DEPTH));
    assign empty = (counts.rd_count == '0);

    always_comb begin
        ram_wr.en   = wr_accept;
        ram_wr.addr = wr_ptr[`FIFO_WORD_PTR_WIDTH-2:0];
        ram_wr.data = data_in;
    end

    always_comb begin
        ram_rd.en   = rd_accept;
        // word address sits just below the wrap bit
        ram_rd.addr = rd_word_ptr[`FIFO_WORD_PTR_WIDTH-2:0];
        ram_rd.lane = rd_ptr[`FIFO_LANE_PTR_WIDTH-`FIFO_WORD_PTR_WIDTH-1:0];
    end

endmodule

`default_nettype wire

// File: design/fifo_status.sv
`timescale 1ns/1ps
`default_nettype none

`include "fifo_settings.svh"

module fifo_status
    import fifo_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        wr_en,
    input  logic        rd_en,
    input  logic        full,
    input  logic        empty,
    input  fifo_count_t counts,
    output fifo_flags_t flags
);

    // error flags hold for the one cycle after the rejected strobe
    logic overflow_q;
    logic underflow_q;

    // a strobe while full or empty was dropped by the pointers
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            overflow_q  <= 1'b0;
            underflow_q <= 1'b0;
        end else begin
            overflow_q  <= wr_en & full;
            underflow_q <= rd_en & empty;
        end
    end

    always_comb begin
        // one word slot left or none
        flags.almost_full  = (counts.wr_count >=
                              `FIFO_WORD_PTR_WIDTH'(`FIFO_DEPTH - 1));
        // at most one lane left
        flags.almost_empty = (counts.rd_count <= `FIFO_LANE_PTR_WIDTH'(1));
        // threshold in words on the write side
        flags.prog_full    = (counts.wr_count >=
                              `FIFO_WORD_PTR_WIDTH'(`FIFO_PROG_FULL_THRESH));
        // threshold in lanes on the read side
        flags.prog_empty   = (counts.rd_count <=
                              `FIFO_LANE_PTR_WIDTH'(`FIFO_PROG_EMPTY_THRESH));
        flags.overflow     = overflow_q;
        flags.underflow    = underflow_q;
    end

endmodule

`default_nettype wire

// File: design/fifo_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "fifo_settings.svh"

module fifo_ram
    import fifo_pkg::*;
(
    input  logic    clock,
    input  ram_wr_t ram_wr,
    input  ram_rd_t ram_rd,
    output word_t   rd_word
);

    // word storage, maps onto block ram
    word_t mem [`FIFO_DEPTH];

    // write port
    always_ff @(posedge clock) begin
        if (ram_wr.en) begin
            mem[ram_wr.addr] <= ram_wr.data;
        end
    end

    // registered read port
    // the output holds the last word while no read is requested
    // a read and a write never share an address, the pointers keep them apart
    always_ff @(posedge clock) begin
        if (ram_rd.en) begin
            rd_word <= mem[ram_rd.addr];
        end
    end

endmodule

`default_nettype wire

// File: design/fifo_lane_unpack.sv
`timescale 1ns/1ps
`default_nettype none

`include "fifo_settings.svh"

module fifo_lane_unpack
    import fifo_pkg::*;
(
    input  logic    clock,
    input  logic    reset,
    input  ram_rd_t ram_rd,
    input  word_t   rd_word,
    output logic    valid,
    output lane_t   data_out
);

    // lane index of the read now leaving the ram
    logic [`FIFO_LANE_PTR_WIDTH-`FIFO_WORD_PTR_WIDTH-1:0] lane_sel;
    // the ram word seen as lanes, element 0 is the least significant
    lane_t [`FIFO_LANES-1:0]                              word_lanes;

    // valid lines up with the ram register, one cycle per accepted read
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            valid <= 1'b0;
        end else begin
            valid <= ram_rd.en;
        end
    end

    // index loads with the same enable as the ram read register
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            lane_sel <= '0;
        end else if (ram_rd.en) begin
            lane_sel <= ram_rd.lane;
        end
    end

    assign word_lanes = rd_word;

    // msb lane first, index 0 picks the top slice
    // lane count is a power of two so inverting the index mirrors it
    assign data_out = word_lanes[~lane_sel];

endmodule

`default_nettype wire

// File: design/fifo_top.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_top
    import fifo_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    // write side, one word per strobe
    input  logic        wr_en,
    input  word_t       data_in,
    output logic        wr_ready,
    output logic        wr_ack,
    // read side, one lane per strobe, data one cycle later
    input  logic        rd_en,
    output logic        valid,
    output lane_t       data_out,
    // status
    output logic        full,
    output logic        empty,
    output fifo_count_t counts,
    output fifo_flags_t flags
);

    // memory requests from the pointer block
    ram_wr_t ram_wr;
    ram_rd_t ram_rd;
    // word coming out of the ram read register
    word_t   rd_word;

    // writes are taken whenever there is a free word slot
    assign wr_ready = ~full;

    // pointers, acceptance and counts
    fifo_pointers u_pointers (
        .clock   (clock),
        .reset   (reset),
        .wr_en   (wr_en),
        .data_in (data_in),
        .rd_en   (rd_en),
        .ram_wr  (ram_wr),
        .ram_rd  (ram_rd),
        .full    (full),
        .empty   (empty),
        .wr_ack  (wr_ack),
        .counts  (counts)
    );

    // word storage
    fifo_ram u_ram (
        .clock   (clock),
        .ram_wr  (ram_wr),
        .ram_rd  (ram_rd),
        .rd_word (rd_word)
    );

    // lane select on the read word
    fifo_lane_unpack u_lane_unpack (
        .clock    (clock),
        .reset    (reset),
        .ram_rd   (ram_rd),
        .rd_word  (rd_word),
        .valid    (valid),
        .data_out (data_out)
    );

    // threshold and error flags
    fifo_status u_status (
        .clock  (clock),
        .reset  (reset),
        .wr_en  (wr_en),
        .rd_en  (rd_en),
        .full   (full),
        .empty  (empty),
        .counts (counts),
        .flags  (flags)
    );

endmodule

`default_nettype wire

// File: dv/fifo_props.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_props
    import fifo_pkg::*;
(
    input logic        clock,
    input logic        reset,
    input logic        wr_ack,
    input logic        valid,
    input logic        full,
    input logic        empty,
    input fifo_flags_t flags
);

    // control outputs idle while reset is held
    reset_state: assert property (@(posedge clock)
        reset |-> (!valid && !wr_ack && !full && empty &&
                   !flags.overflow && !flags.underflow))
        else $error("control outputs not idle during reset");

    // a write to a full FIFO is never acknowledged
    no_ack_when_full: assert property (@(posedge clock) disable iff (reset)
        !(wr_ack && full))
        else $error("wr_ack high while full");

    full_implies_flags: assert property (@(posedge clock) disable iff (reset)
        full |-> (flags.almost_full && flags.prog_full))
        else $error("full without almost_full or prog_full");

    empty_implies_flags: assert property (@(posedge clock) disable iff (reset)
        empty |-> (flags.almost_empty && flags.prog_empty))
        else $error("empty without almost_empty or prog_empty");

endmodule

bind fifo_top fifo_props u_props (
    .clock  (clock),
    .reset  (reset),
    .wr_ack (wr_ack),
    .valid  (valid),
    .full   (full),
    .empty  (empty),
    .flags  (flags)
);

`default_nettype wire

// File: dv/fifo_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fifo_settings.svh"

module fifo_tb
    import fifo_pkg::*;
();

    logic        clock;
    logic        reset;
    logic        wr_en;
    word_t       data_in;
    logic        wr_ready;
    logic        wr_ack;
    logic        rd_en;
    logic        valid;
    lane_t       data_out;
    logic        full;
    logic        empty;
    fifo_count_t counts;
    fifo_flags_t flags;

    // reference model, lanes in the order they must come out
    lane_t lanes_q[$];
    // what the last edge should show during the following cycle
    int    exp_valid;
    lane_t exp_lane;
    int    exp_overflow;
    int    exp_underflow;
    int    seed;

    fifo_top uut (
        .clock    (clock),
        .reset    (reset),
        .wr_en    (wr_en),
        .data_in  (data_in),
        .wr_ready (wr_ready),
        .wr_ack   (wr_ack),
        .rd_en    (rd_en),
        .valid    (valid),
        .data_out (data_out),
        .full     (full),
        .empty    (empty),
        .counts   (counts),
        .flags    (flags)
    );

    // 4 ns period
    always #2 clock = ~clock;

    function automatic int model_lanes();
        return lanes_q.size();
    endfunction

    // a partly read word still holds its slot
    function automatic int model_words();
        return (lanes_q.size() + `FIFO_LANES - 1) / `FIFO_LANES;
    endfunction

    task automatic abort_run();
        $display("Test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(input string name, input int exp, input int act);
        $display("FAILED at %0t: %s expected 'h%0h, got 'h%0h", $time, name, exp, act);
        abort_run();
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        abort_run();
    endtask

    task automatic expect_equal(input string name, input int exp, input int act);
        assert (exp == act) else report_mismatch(name, exp, act);
    endtask

    task automatic check_outputs(input logic wr);
        // write is judged against full before this cycle's read
        expect_equal("wr_ack", int'(wr && model_words() < `FIFO_DEPTH), int'(wr_ack));
        expect_equal("full", int'(model_words() == `FIFO_DEPTH), int'(full));
        expect_equal("wr_ready", int'(model_words() != `FIFO_DEPTH), int'(wr_ready));
        expect_equal("empty", int'(model_lanes() == 0), int'(empty));
        expect_equal("wr_count", model_words(), int'(counts.wr_count));
        expect_equal("rd_count", model_lanes(), int'(counts.rd_count));
        expect_equal("almost_full", int'(model_words() >= `FIFO_DEPTH - 1),
                     int'(flags.almost_full));
        expect_equal("almost_empty", int'(model_lanes() <= 1), int'(flags.almost_empty));
        expect_equal("prog_full", int'(model_words() >= `FIFO_PROG_FULL_THRESH),
                     int'(flags.prog_full));
        expect_equal("prog_empty", int'(model_lanes() <= `FIFO_PROG_EMPTY_THRESH),
                     int'(flags.prog_empty));
        expect_equal("valid", exp_valid, int'(valid));
        if (exp_valid != 0) begin
            expect_equal("data_out", int'(exp_lane), int'(data_out));
        end
        expect_equal("overflow", exp_overflow, int'(flags.overflow));
        expect_equal("underflow", exp_underflow, int'(flags.underflow));
    endtask

    // one clock cycle, entered and left 1 ns after a rising edge
    task automatic step(input logic wr, input word_t word, input logic rd);
        int   i;
        logic wr_accept;
        logic rd_accept;
        wr_en   = wr;
        data_in = word;
        rd_en   = rd;
        #1;
        check_outputs(wr);
        wr_accept     = wr && (model_words() < `FIFO_DEPTH);
        rd_accept     = rd && (model_lanes() != 0);
        exp_overflow  = int'(wr && !wr_accept);
        exp_underflow = int'(rd && !rd_accept);
        exp_valid     = int'(rd_accept);
        if (rd_accept) begin
            exp_lane = lanes_q.pop_front();
        end
        if (wr_accept) begin
            // top lane of the word leaves first
            for (i = `FIFO_LANES - 1; i >= 0; i--) begin
                lanes_q.push_back(word[i*`FIFO_LANE_WIDTH +: `FIFO_LANE_WIDTH]);
            end
        end
        @(posedge clock);
        #1;
    endtask

    initial begin
        int r;
        int n;
        int waited;
        seed          = 32'hb6d9_4525;
        clock         = 1'b0;
        reset         = 1'b1;
        wr_en         = 1'b0;
        data_in       = '0;
        rd_en         = 1'b0;
        exp_valid     = 0;
        exp_lane      = '0;
        exp_overflow  = 0;
        exp_underflow = 0;
        repeat (3) @(posedge clock);
        #1;
        reset = 1'b0;
        step(1'b0, '0, 1'b0);
        // mixed traffic, first filling then mostly draining
        for (n = 0; n < 300; n++) begin
            r = $random(seed);
            if (n < 150) begin
                step(r[0], word_t'($random(seed)), r[1] | r[2]);
            end else begin
                step(r[2:0] == 3'd0, word_t'($random(seed)), 1'b1);
            end
        end
        waited = 0;
        while (!empty) begin
            if (waited >= 100) report_timeout("drain after random traffic");
            else begin
                step(1'b0, '0, 1'b1);
                waited++;
            end
        end
        // fill to full, then one write too many
        waited = 0;
        while (!full) begin
            if (waited >= 40) report_timeout("full");
            else begin
                step(1'b1, word_t'($random(seed)), 1'b0);
                waited++;
            end
        end
        step(1'b1, word_t'($random(seed)), 1'b0);
        step(1'b0, '0, 1'b0);
        // drain every lane, then one read too many
        waited = 0;
        while (!empty) begin
            if (waited >= 100) report_timeout("empty");
            else begin
                step(1'b0, '0, 1'b1);
                waited++;
            end
        end
        step(1'b0, '0, 1'b1);
        step(1'b0, '0, 1'b0);
        step(1'b0, '0, 1'b0);
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+design
design/fifo_pkg.sv
design/fifo_pointers.sv
design/fifo_status.sv
design/fifo_ram.sv
design/fifo_lane_unpack.sv
design/fifo_top.sv
dv/fifo_props.sv
dv/fifo_tb.sv

// File: run.sh
#!/bin/sh
# build the FIFO testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f vlog.f --top-module fifo_tb -o fifo_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/fifo_sim 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Test passed"; then
    exit 0
else
    echo "simulation did not report a pass"
    exit 1
fi
